// ==== verilog/roc_cfg.svh ====
/* Widths, line count and region count of the read-only cache */

`ifndef ROC_CFG_SVH
`define ROC_CFG_SVH

// Word address and data widths
`define ROC_ADDR_W 16
`define ROC_DATA_W 32

// Direct-mapped array, one word per line
`define ROC_LINE_COUNT 16
`define ROC_IDX_W 4

// Number of runtime-programmed cacheable regions
`define ROC_NR_RULES 2

`endif

// ==== verilog/roc_pkg.sv ====
/* Shared enums of the read-only cache: opcode, route, port owner, lookup FSM */

package roc_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // Which path serves the accepted request
  typedef enum logic {
    ROUTE_BYPASS = 1'b0,
    ROUTE_CACHE  = 1'b1
  } route_e;

  typedef enum logic {
    OWN_CACHE  = 1'b0,
    OWN_BYPASS = 1'b1
  } owner_e;

  typedef enum logic [2:0] {
    LK_IDLE, LK_TAG, LK_REFILL, LK_WAIT, LK_FLUSH
  } lookup_state_e;

endpackage

// ==== verilog/roc_region_decode.sv ====
/* Region decoder: routes each request to the cache or bypass path
   and tracks the single outstanding transaction */
`timescale 1ns/1ps
`include "roc_cfg.svh"

module roc_region_decode #(
  parameter int unsigned NrRules = `ROC_NR_RULES
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                enable_i,
  input  logic [NrRules-1:0][`ROC_ADDR_W-1:0] start_addr_i,
  input  logic [NrRules-1:0][`ROC_ADDR_W-1:0] end_addr_i,
  input  logic                                req_valid_i,
  input  roc_pkg::op_e                        req_op_i,
  input  logic [`ROC_ADDR_W-1:0]              req_addr_i,
  input  logic [`ROC_DATA_W-1:0]              req_wdata_i,
  output logic                                req_ready_o,
  input  logic                                flush_busy_i,
  input  logic                                done_i,
  output logic                                cache_valid_o,
  output logic                                byp_valid_o,
  output roc_pkg::op_e                        fwd_op_o,
  output logic [`ROC_ADDR_W-1:0]              fwd_addr_o,
  output logic [`ROC_DATA_W-1:0]              fwd_wdata_o
);

  logic            rule_hit;
  logic            accept;
  roc_pkg::route_e route;
  logic            busy_q;

  // Region match, start inclusive and end exclusive
  always_comb begin
    rule_hit = 1'b0;
    for (int i = 0; i < NrRules; i++) begin
      if (req_addr_i >= start_addr_i[i] && req_addr_i < end_addr_i[i]) begin
        rule_hit = 1'b1;
      end
    end
  end

  // Only enabled reads inside a region are cacheable
  assign route = (enable_i && req_op_i == roc_pkg::OP_READ && rule_hit) ?
                 roc_pkg::ROUTE_CACHE : roc_pkg::ROUTE_BYPASS;

  assign req_ready_o = !busy_q && !flush_busy_i;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q        <= 1'b0;
      cache_valid_o <= 1'b0;
      byp_valid_o   <= 1'b0;
    end else begin
      cache_valid_o <= accept && (route == roc_pkg::ROUTE_CACHE);
      byp_valid_o   <= accept && (route == roc_pkg::ROUTE_BYPASS);
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Request fields stay put until the transaction ends
  always_ff @(posedge clk_i) begin
    if (accept) begin
      fwd_op_o    <= req_op_i;
      fwd_addr_o  <= req_addr_i;
      fwd_wdata_o <= req_wdata_i;
    end
  end

endmodule

// ==== verilog/roc_lookup.sv ====
/* Direct-mapped lookup: tag, data and valid arrays, hit check,
   single-word refill and flush walker */
`timescale 1ns/1ps
`include "roc_cfg.svh"

module roc_lookup (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   in_valid_i,
  input  logic [`ROC_ADDR_W-1:0] in_addr_i,
  input  logic                   flush_valid_i,
  output logic                   flush_ready_o,
  output logic                   flush_busy_o,
  output logic                   mem_valid_o,
  output logic [`ROC_ADDR_W-1:0] mem_addr_o,
  input  logic                   mem_ready_i,
  input  logic                   mem_rsp_valid_i,
  input  logic [`ROC_DATA_W-1:0] mem_rsp_rdata_i,
  output logic                   done_o,
  output logic [`ROC_DATA_W-1:0] rdata_o
);

  localparam int unsigned IdxW    = `ROC_IDX_W;
  localparam int unsigned TagW    = `ROC_ADDR_W - `ROC_IDX_W;
  localparam logic [IdxW-1:0] LastIdx = IdxW'(`ROC_LINE_COUNT - 1);

  // Arrays
  logic [`ROC_DATA_W-1:0]    data_mem [`ROC_LINE_COUNT];
  logic [TagW-1:0]           tag_mem  [`ROC_LINE_COUNT];
  logic [`ROC_LINE_COUNT-1:0] valid_q;

  roc_pkg::lookup_state_e    state_q;
  logic [IdxW-1:0]           flush_idx_q;
  logic [`ROC_ADDR_W-1:0]    addr_q;
  logic [TagW-1:0]           tag_rd_q;
  logic [`ROC_DATA_W-1:0]    data_rd_q;
  logic                      valid_rd_q;
  logic [IdxW-1:0]           in_idx;
  logic [IdxW-1:0]           idx_q;
  logic                      start;
  logic                      hit;
  logic                      refill_fire;

  assign in_idx      = in_addr_i[IdxW-1:0];
  assign idx_q       = addr_q[IdxW-1:0];
  assign start       = (state_q == roc_pkg::LK_IDLE) && in_valid_i;
  assign hit         = valid_rd_q && (tag_rd_q == addr_q[`ROC_ADDR_W-1:IdxW]);
  assign refill_fire = (state_q == roc_pkg::LK_WAIT) && mem_rsp_valid_i;

  assign mem_valid_o  = (state_q == roc_pkg::LK_REFILL);
  assign mem_addr_o   = addr_q;
  // A pending flush also blocks new requests at the front end
  assign flush_busy_o = (state_q == roc_pkg::LK_FLUSH) || flush_valid_i;

  // ----------------------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q       <= roc_pkg::LK_IDLE;
      valid_q       <= '0;
      flush_idx_q   <= '0;
      done_o        <= 1'b0;
      flush_ready_o <= 1'b0;
    end else begin
      done_o        <= 1'b0;
      flush_ready_o <= 1'b0;
      unique case (state_q)
        roc_pkg::LK_IDLE: begin
          // Request wins over a flush arriving in the same cycle
          if (in_valid_i) begin
            state_q <= roc_pkg::LK_TAG;
          end else if (flush_valid_i && !flush_ready_o) begin
            state_q     <= roc_pkg::LK_FLUSH;
            flush_idx_q <= '0;
          end
        end
        roc_pkg::LK_TAG: begin
          if (hit) begin
            done_o  <= 1'b1;
            state_q <= roc_pkg::LK_IDLE;
          end else begin
            state_q <= roc_pkg::LK_REFILL;
          end
        end
        roc_pkg::LK_REFILL: begin
          if (mem_ready_i) begin
            state_q <= roc_pkg::LK_WAIT;
          end
        end
        roc_pkg::LK_WAIT: begin
          if (mem_rsp_valid_i) begin
            valid_q[idx_q] <= 1'b1;
            done_o         <= 1'b1;
            state_q        <= roc_pkg::LK_IDLE;
          end
        end
        roc_pkg::LK_FLUSH: begin
          valid_q[flush_idx_q] <= 1'b0;
          flush_idx_q          <= flush_idx_q + 1'b1;
          if (flush_idx_q == LastIdx) begin
            flush_ready_o <= 1'b1;
            state_q       <= roc_pkg::LK_IDLE;
          end
        end
        default: state_q <= roc_pkg::LK_IDLE;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Array access and datapath
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (start) begin
      addr_q     <= in_addr_i;
      tag_rd_q   <= tag_mem[in_idx];
      data_rd_q  <= data_mem[in_idx];
      valid_rd_q <= valid_q[in_idx];
    end
    if (refill_fire) begin
      tag_mem[idx_q]  <= addr_q[`ROC_ADDR_W-1:IdxW];
      data_mem[idx_q] <= mem_rsp_rdata_i;
    end
    // Output register, hit data or refilled word
    if (state_q == roc_pkg::LK_TAG && hit) begin
      rdata_o <= data_rd_q;
    end else if (refill_fire) begin
      rdata_o <= mem_rsp_rdata_i;
    end
  end

endmodule

// ==== verilog/roc_bypass.sv ====
/* Bypass path: forwards one uncached read or write to memory
   and returns its answer */
`timescale 1ns/1ps
`include "roc_cfg.svh"

module roc_bypass (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   in_valid_i,
  input  roc_pkg::op_e           in_op_i,
  input  logic [`ROC_ADDR_W-1:0] in_addr_i,
  input  logic [`ROC_DATA_W-1:0] in_wdata_i,
  output logic                   mem_valid_o,
  output logic                   mem_write_o,
  output logic [`ROC_ADDR_W-1:0] mem_addr_o,
  output logic [`ROC_DATA_W-1:0] mem_wdata_o,
  input  logic                   mem_ready_i,
  input  logic                   mem_rsp_valid_i,
  input  logic [`ROC_DATA_W-1:0] mem_rsp_rdata_i,
  output logic                   done_o,
  output logic [`ROC_DATA_W-1:0] rdata_o
);

  logic         pend_q;
  logic         wait_q;
  roc_pkg::op_e op_q;

  assign mem_valid_o = pend_q;
  assign mem_write_o = (op_q == roc_pkg::OP_WRITE);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pend_q <= 1'b0;
      wait_q <= 1'b0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (in_valid_i) begin
        pend_q <= 1'b1;
      end else if (pend_q && mem_ready_i) begin
        pend_q <= 1'b0;
        wait_q <= 1'b1;
      end else if (wait_q && mem_rsp_valid_i) begin
        wait_q <= 1'b0;
        done_o <= 1'b1;
      end
    end
  end

  // Held request and returned data
  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      op_q        <= in_op_i;
      mem_addr_o  <= in_addr_i;
      mem_wdata_o <= in_wdata_i;
    end
    if (wait_q && mem_rsp_valid_i) begin
      // Writes answer with zero data
      rdata_o <= mem_write_o ? '0 : mem_rsp_rdata_i;
    end
  end

endmodule

// ==== verilog/roc_mem_arbiter.sv ====
/* Memory arbiter: fixed-priority merge of cache refills and bypass traffic
   onto one port, response steering and requester response merge */
`timescale 1ns/1ps
`include "roc_cfg.svh"

module roc_mem_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  // Cache refill side
  input  logic                   c_mem_valid_i,
  input  logic [`ROC_ADDR_W-1:0] c_mem_addr_i,
  output logic                   c_mem_ready_o,
  output logic                   c_rsp_valid_o,
  // Bypass side
  input  logic                   b_mem_valid_i,
  input  logic                   b_mem_write_i,
  input  logic [`ROC_ADDR_W-1:0] b_mem_addr_i,
  input  logic [`ROC_DATA_W-1:0] b_mem_wdata_i,
  output logic                   b_mem_ready_o,
  output logic                   b_rsp_valid_o,
  // Memory port
  output logic                   mem_req_valid_o,
  output logic                   mem_req_write_o,
  output logic [`ROC_ADDR_W-1:0] mem_req_addr_o,
  output logic [`ROC_DATA_W-1:0] mem_req_wdata_o,
  input  logic                   mem_req_ready_i,
  input  logic                   mem_rsp_valid_i,
  // Path completions and requester response
  input  logic                   c_done_i,
  input  logic [`ROC_DATA_W-1:0] c_rdata_i,
  input  logic                   b_done_i,
  input  logic [`ROC_DATA_W-1:0] b_rdata_i,
  output logic                   rsp_valid_o,
  output logic [`ROC_DATA_W-1:0] rsp_rdata_o
);

  logic            sel_cache;
  roc_pkg::owner_e owner_q;

  // Cache refills take precedence
  assign sel_cache = c_mem_valid_i;

  assign mem_req_valid_o = c_mem_valid_i || b_mem_valid_i;
  assign mem_req_write_o = sel_cache ? 1'b0 : b_mem_write_i;
  assign mem_req_addr_o  = sel_cache ? c_mem_addr_i : b_mem_addr_i;
  assign mem_req_wdata_o = sel_cache ? '0 : b_mem_wdata_i;

  assign c_mem_ready_o = mem_req_ready_i && sel_cache;
  assign b_mem_ready_o = mem_req_ready_i && !sel_cache;

  // Remember who owns the outstanding memory response
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      owner_q <= roc_pkg::OWN_CACHE;
    end else if (mem_req_valid_o && mem_req_ready_i) begin
      owner_q <= sel_cache ? roc_pkg::OWN_CACHE : roc_pkg::OWN_BYPASS;
    end
  end

  assign c_rsp_valid_o = mem_rsp_valid_i && (owner_q == roc_pkg::OWN_CACHE);
  assign b_rsp_valid_o = mem_rsp_valid_i && (owner_q == roc_pkg::OWN_BYPASS);

  // ----------------------------------------------------------------------
  // Response merge, at most one done pulse per transaction
  // ----------------------------------------------------------------------
  assign rsp_valid_o = c_done_i || b_done_i;
  assign rsp_rdata_o = b_done_i ? b_rdata_i : c_rdata_i;

endmodule

// ==== verilog/roc_top.sv ====
/* Read-only cache top level: region decoder, lookup, bypass and
   memory arbiter */
`timescale 1ns/1ps
`include "roc_cfg.svh"

module roc_top (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  // Requester
  input  logic                                      req_valid_i,
  input  roc_pkg::op_e                              req_op_i,
  input  logic [`ROC_ADDR_W-1:0]                    req_addr_i,
  input  logic [`ROC_DATA_W-1:0]                    req_wdata_i,
  output logic                                      req_ready_o,
  output logic                                      rsp_valid_o,
  output logic [`ROC_DATA_W-1:0]                    rsp_rdata_o,
  // Configuration and flush
  input  logic                                      enable_i,
  input  logic [`ROC_NR_RULES-1:0][`ROC_ADDR_W-1:0] start_addr_i,
  input  logic [`ROC_NR_RULES-1:0][`ROC_ADDR_W-1:0] end_addr_i,
  input  logic                                      flush_valid_i,
  output logic                                      flush_ready_o,
  // Memory
  output logic                                      mem_req_valid_o,
  output logic                                      mem_req_write_o,
  output logic [`ROC_ADDR_W-1:0]                    mem_req_addr_o,
  output logic [`ROC_DATA_W-1:0]                    mem_req_wdata_o,
  input  logic                                      mem_req_ready_i,
  input  logic                                      mem_rsp_valid_i,
  input  logic [`ROC_DATA_W-1:0]                    mem_rsp_rdata_i
);

  logic                   cache_valid;
  logic                   byp_valid;
  roc_pkg::op_e           fwd_op;
  logic [`ROC_ADDR_W-1:0] fwd_addr;
  logic [`ROC_DATA_W-1:0] fwd_wdata;
  logic                   flush_busy;

  logic                   c_mem_valid;
  logic [`ROC_ADDR_W-1:0] c_mem_addr;
  logic                   c_mem_ready;
  logic                   c_rsp_valid;
  logic                   c_done;
  logic [`ROC_DATA_W-1:0] c_rdata;

  logic                   b_mem_valid;
  logic                   b_mem_write;
  logic [`ROC_ADDR_W-1:0] b_mem_addr;
  logic [`ROC_DATA_W-1:0] b_mem_wdata;
  logic                   b_mem_ready;
  logic                   b_rsp_valid;
  logic                   b_done;
  logic [`ROC_DATA_W-1:0] b_rdata;

  roc_region_decode #(
    .NrRules ( `ROC_NR_RULES )
  ) u_decode (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .enable_i      ( enable_i      ),
    .start_addr_i  ( start_addr_i  ),
    .end_addr_i    ( end_addr_i    ),
    .req_valid_i   ( req_valid_i   ),
    .req_op_i      ( req_op_i      ),
    .req_addr_i    ( req_addr_i    ),
    .req_wdata_i   ( req_wdata_i   ),
    .req_ready_o   ( req_ready_o   ),
    .flush_busy_i  ( flush_busy    ),
    .done_i        ( rsp_valid_o   ),
    .cache_valid_o ( cache_valid   ),
    .byp_valid_o   ( byp_valid     ),
    .fwd_op_o      ( fwd_op        ),
    .fwd_addr_o    ( fwd_addr      ),
    .fwd_wdata_o   ( fwd_wdata     )
  );

  roc_lookup u_lookup (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .in_valid_i      ( cache_valid     ),
    .in_addr_i       ( fwd_addr        ),
    .flush_valid_i   ( flush_valid_i   ),
    .flush_ready_o   ( flush_ready_o   ),
    .flush_busy_o    ( flush_busy      ),
    .mem_valid_o     ( c_mem_valid     ),
    .mem_addr_o      ( c_mem_addr      ),
    .mem_ready_i     ( c_mem_ready     ),
    .mem_rsp_valid_i ( c_rsp_valid     ),
    .mem_rsp_rdata_i ( mem_rsp_rdata_i ),
    .done_o          ( c_done          ),
    .rdata_o         ( c_rdata         )
  );

  roc_bypass u_bypass (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .in_valid_i      ( byp_valid       ),
    .in_op_i         ( fwd_op          ),
    .in_addr_i       ( fwd_addr        ),
    .in_wdata_i      ( fwd_wdata       ),
    .mem_valid_o     ( b_mem_valid     ),
    .mem_write_o     ( b_mem_write     ),
    .mem_addr_o      ( b_mem_addr      ),
    .mem_wdata_o     ( b_mem_wdata     ),
    .mem_ready_i     ( b_mem_ready     ),
    .mem_rsp_valid_i ( b_rsp_valid     ),
    .mem_rsp_rdata_i ( mem_rsp_rdata_i ),
    .done_o          ( b_done          ),
    .rdata_o         ( b_rdata         )
  );

  roc_mem_arbiter u_arbiter (
    .clk_i           ( clk_i           ),
    .rst_n_i         ( rst_n_i         ),
    .c_mem_valid_i   ( c_mem_valid     ),
    .c_mem_addr_i    ( c_mem_addr      ),
    .c_mem_ready_o   ( c_mem_ready     ),
    .c_rsp_valid_o   ( c_rsp_valid     ),
    .b_mem_valid_i   ( b_mem_valid     ),
    .b_mem_write_i   ( b_mem_write     ),
    .b_mem_addr_i    ( b_mem_addr      ),
    .b_mem_wdata_i   ( b_mem_wdata     ),
    .b_mem_ready_o   ( b_mem_ready     ),
    .b_rsp_valid_o   ( b_rsp_valid     ),
    .mem_req_valid_o ( mem_req_valid_o ),
    .mem_req_write_o ( mem_req_write_o ),
    .mem_req_addr_o  ( mem_req_addr_o  ),
    .mem_req_wdata_o ( mem_req_wdata_o ),
    .mem_req_ready_i ( mem_req_ready_i ),
    .mem_rsp_valid_i ( mem_rsp_valid_i ),
    .c_done_i        ( c_done          ),
    .c_rdata_i       ( c_rdata         ),
    .b_done_i        ( b_done          ),
    .b_rdata_i       ( b_rdata         ),
    .rsp_valid_o     ( rsp_valid_o     ),
    .rsp_rdata_o     ( rsp_rdata_o     )
  );

endmodule

// ==== test/roc_checker.sv ====
/* Concurrent assertions on the cache top-level ports, bound to roc_top */
`timescale 1ns/1ps
`include "roc_cfg.svh"

module roc_checker (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   req_valid_i,
  input logic                   req_ready_o,
  input logic                   rsp_valid_o,
  input logic                   flush_ready_o,
  input logic                   mem_req_valid_o,
  input logic                   mem_req_write_o,
  input logic [`ROC_ADDR_W-1:0] mem_req_addr_o,
  input logic [`ROC_DATA_W-1:0] mem_req_wdata_o,
  input logic                   mem_req_ready_i
);

  logic outstanding_q;
  logic assert_failed = 1'b0;

  // Set on acceptance, cleared by the response pulse
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      outstanding_q <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      outstanding_q <= 1'b1;
    end else if (rsp_valid_o) begin
      outstanding_q <= 1'b0;
    end
  end

  a_ready_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    outstanding_q |-> !req_ready_o)
  else begin
    $error("req_ready_o high while a request is outstanding");
    assert_failed = 1'b1;
  end

  a_mem_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_req_valid_o && !mem_req_ready_i) |=> (mem_req_valid_o &&
      $stable(mem_req_write_o) && $stable(mem_req_addr_o) && $stable(mem_req_wdata_o)))
  else begin
    $error("memory request changed while stalled");
    assert_failed = 1'b1;
  end

  a_rsp_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_o |=> !rsp_valid_o)
  else begin
    $error("rsp_valid_o longer than one cycle");
    assert_failed = 1'b1;
  end

  a_flush_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_ready_o |=> !flush_ready_o)
  else begin
    $error("flush_ready_o longer than one cycle");
    assert_failed = 1'b1;
  end

  // Outputs idle the cycle after a reset edge
  a_reset_idle: assert property (@(posedge clk_i)
    !rst_n_i |=> (req_ready_o && !rsp_valid_o && !mem_req_valid_o && !flush_ready_o))
  else begin
    $error("outputs not idle after reset");
    assert_failed = 1'b1;
  end

endmodule

bind roc_top roc_checker u_checker (.*);

// ==== test/roc_tb.sv ====
/* Testbench for the read-only cache: clock, reset, memory model,
   stimulus table with a reference model of valid bits and tags */
`timescale 1ns/1ps
`include "roc_cfg.svh"

module roc_tb;

  localparam int TIMEOUT     = 200;
  localparam int MAX_ENTRIES = 32;
  localparam int K_READ      = 0;
  localparam int K_WRITE     = 1;
  localparam int K_FLUSH     = 2;
  localparam logic [`ROC_ADDR_W-1:0] R0_START = 16'h0100;
  localparam logic [`ROC_ADDR_W-1:0] R0_END   = 16'h0140;
  localparam logic [`ROC_ADDR_W-1:0] R1_START = 16'h2000;
  localparam logic [`ROC_ADDR_W-1:0] R1_END   = 16'h2010;

  logic                                      clk_i = 1'b0;
  logic                                      rst_n_i;
  logic                                      req_valid_i;
  roc_pkg::op_e                              req_op_i;
  logic [`ROC_ADDR_W-1:0]                    req_addr_i;
  logic [`ROC_DATA_W-1:0]                    req_wdata_i;
  logic                                      req_ready_o;
  logic                                      rsp_valid_o;
  logic [`ROC_DATA_W-1:0]                    rsp_rdata_o;
  logic                                      enable_i;
  logic [`ROC_NR_RULES-1:0][`ROC_ADDR_W-1:0] start_addr_i;
  logic [`ROC_NR_RULES-1:0][`ROC_ADDR_W-1:0] end_addr_i;
  logic                                      flush_valid_i;
  logic                                      flush_ready_o;
  logic                                      mem_req_valid_o;
  logic                                      mem_req_write_o;
  logic [`ROC_ADDR_W-1:0]                    mem_req_addr_o;
  logic [`ROC_DATA_W-1:0]                    mem_req_wdata_o;
  logic                                      mem_req_ready_i = 1'b0;
  logic                                      mem_rsp_valid_i = 1'b0;
  logic [`ROC_DATA_W-1:0]                    mem_rsp_rdata_i = '0;

  // Stimulus table and reference model state
  int                                    tab_kind  [MAX_ENTRIES];
  logic                                  tab_en    [MAX_ENTRIES];
  logic [`ROC_ADDR_W-1:0]                tab_addr  [MAX_ENTRIES];
  logic [`ROC_DATA_W-1:0]                tab_wdata [MAX_ENTRIES];
  logic [`ROC_DATA_W-1:0]                tab_rdata [MAX_ENTRIES];
  int                                    tab_count = 0;
  logic [`ROC_LINE_COUNT-1:0]            ref_valid;
  logic [`ROC_ADDR_W-`ROC_IDX_W-1:0]     ref_tag [`ROC_LINE_COUNT];

  always #4 clk_i = ~clk_i;

  roc_top u_dut (.*);

  // Preset memory word, a function of every address bit
  function automatic logic [`ROC_DATA_W-1:0] mem_pattern(input logic [`ROC_ADDR_W-1:0] a);
    return {a ^ 16'ha5c3, ~a + 16'h0137};
  endfunction

  function automatic logic in_region(input logic [`ROC_ADDR_W-1:0] a);
    return (a >= R0_START && a < R0_END) || (a >= R1_START && a < R1_END);
  endfunction

  // ----------------------------------------------------------------------
  // Memory model
  // ----------------------------------------------------------------------
  logic [`ROC_DATA_W-1:0] mem_array [2**`ROC_ADDR_W];
  int                     mem_state = 0;
  int                     mem_dly = 0;
  int                     mem_req_count = 0;
  logic [`ROC_ADDR_W-1:0] last_req_addr = '0;
  logic [`ROC_DATA_W-1:0] rsp_data = '0;

  // Random ready and response delays come from this process
  initial begin
    void'($urandom(32'h1cab_613f));
    forever begin
      @(posedge clk_i);
      mem_rsp_valid_i <= 1'b0;
      if (!rst_n_i) begin
        for (int a = 0; a < 2**`ROC_ADDR_W; a++) begin
          mem_array[a] = mem_pattern(16'(a));
        end
        mem_req_ready_i <= 1'b0;
        mem_state       <= 0;
      end else begin
        case (mem_state)
          0: begin
            if (mem_req_valid_o) begin
              mem_dly   <= $urandom_range(3, 0);
              mem_state <= 1;
            end
          end
          1: begin
            if (mem_dly == 0) begin
              mem_req_ready_i <= 1'b1;
              mem_state       <= 2;
            end else begin
              mem_dly <= mem_dly - 1;
            end
          end
          2: begin
            // Request taken at this edge
            mem_req_ready_i <= 1'b0;
            mem_req_count   <= mem_req_count + 1;
            last_req_addr   <= mem_req_addr_o;
            // Writes answer with the old word, which the DUT must drop
            rsp_data <= mem_array[mem_req_addr_o];
            if (mem_req_write_o) begin
              mem_array[mem_req_addr_o] = mem_req_wdata_o;
            end
            mem_dly   <= $urandom_range(3, 0);
            mem_state <= 3;
          end
          default: begin
            if (mem_dly == 0) begin
              mem_rsp_valid_i <= 1'b1;
              mem_rsp_rdata_i <= rsp_data;
              mem_state       <= 0;
            end else begin
              mem_dly <= mem_dly - 1;
            end
          end
        endcase
      end
    end
  end

  // ----------------------------------------------------------------------
  // Checks and failure handling
  // ----------------------------------------------------------------------
  task automatic stop_with_failure();
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout at %0t ns: no %s within %0d cycles", $time, what, TIMEOUT);
    stop_with_failure();
  endtask

  always @(negedge clk_i) begin
    if (u_dut.u_checker.assert_failed) begin
      $display("A bound assertion failed");
      stop_with_failure();
    end
  end

  task automatic add_entry(input int kind, input logic en, input logic [15:0] addr,
                           input logic [31:0] wdata, input logic [31:0] rdata);
    tab_kind[tab_count]  = kind;
    tab_en[tab_count]    = en;
    tab_addr[tab_count]  = addr;
    tab_wdata[tab_count] = wdata;
    tab_rdata[tab_count] = rdata;
    tab_count++;
  endtask

  task automatic run_flush();
    int waited;
    waited = 0;
    @(posedge clk_i);
    flush_valid_i <= 1'b1;
    @(negedge clk_i);
    while (!flush_ready_o) begin
      waited++;
      if (waited > TIMEOUT) report_timeout("flush_ready_o");
      @(negedge clk_i);
    end
    @(posedge clk_i);
    flush_valid_i <= 1'b0;
    ref_valid = '0;
  endtask

  task automatic run_access(input int k);
    logic                              cached;
    logic                              hit;
    int                                exp_reqs;
    int                                reqs_before;
    int                                waited;
    int                                edges;
    logic [`ROC_IDX_W-1:0]             idx;
    logic [`ROC_ADDR_W-`ROC_IDX_W-1:0] tag;
    idx    = tab_addr[k][`ROC_IDX_W-1:0];
    tag    = tab_addr[k][`ROC_ADDR_W-1:`ROC_IDX_W];
    cached = tab_en[k] && tab_kind[k] == K_READ && in_region(tab_addr[k]);
    hit    = cached && ref_valid[idx] && ref_tag[idx] == tag;
    exp_reqs = hit ? 0 : 1;
    if (cached) begin
      ref_valid[idx] = 1'b1;
      ref_tag[idx]   = tag;
    end
    reqs_before = mem_req_count;
    @(posedge clk_i);
    enable_i    <= tab_en[k];
    req_valid_i <= 1'b1;
    req_op_i    <= (tab_kind[k] == K_WRITE) ? roc_pkg::OP_WRITE : roc_pkg::OP_READ;
    req_addr_i  <= tab_addr[k];
    req_wdata_i <= tab_wdata[k];
    waited = 0;
    @(negedge clk_i);
    while (!req_ready_o) begin
      waited++;
      if (waited > TIMEOUT) report_timeout("req_ready_o");
      @(negedge clk_i);
    end
    // Acceptance edge
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    edges = 0;
    do begin
      @(posedge clk_i);
      edges++;
      @(negedge clk_i);
      if (edges > TIMEOUT) report_timeout("rsp_valid_o");
    end while (!rsp_valid_o);
    check_value("rsp_rdata_o", rsp_rdata_o, tab_rdata[k]);
    check_value("memory request count", mem_req_count - reqs_before, exp_reqs);
    if (exp_reqs == 1) check_value("mem_req_addr_o", last_req_addr, tab_addr[k]);
    if (hit) check_value("hit latency", edges, 2);
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    rst_n_i         = 1'b0;
    req_valid_i     = 1'b0;
    req_op_i        = roc_pkg::OP_READ;
    req_addr_i      = '0;
    req_wdata_i     = '0;
    enable_i        = 1'b0;
    flush_valid_i   = 1'b0;
    start_addr_i[0] = R0_START;
    end_addr_i[0]   = R0_END;
    start_addr_i[1] = R1_START;
    end_addr_i[1]   = R1_END;
    ref_valid       = '0;

    // Cold miss then hit, bypass reads and writes
    add_entry(K_READ,  1'b1, 16'h0104, '0, mem_pattern(16'h0104));
    add_entry(K_READ,  1'b1, 16'h0104, '0, mem_pattern(16'h0104));
    add_entry(K_READ,  1'b1, 16'h0800, '0, mem_pattern(16'h0800));
    add_entry(K_READ,  1'b1, 16'h0800, '0, mem_pattern(16'h0800));
    add_entry(K_WRITE, 1'b1, 16'h0900, 32'hdead_0900, '0);
    add_entry(K_READ,  1'b1, 16'h0900, '0, 32'hdead_0900);
    // Stale copy until a flush
    add_entry(K_WRITE, 1'b1, 16'h0104, 32'h1234_5678, '0);
    add_entry(K_READ,  1'b1, 16'h0104, '0, mem_pattern(16'h0104));
    add_entry(K_FLUSH, 1'b1, '0, '0, '0);
    add_entry(K_READ,  1'b1, 16'h0104, '0, 32'h1234_5678);
    add_entry(K_READ,  1'b1, 16'h0104, '0, 32'h1234_5678);
    // Cache disabled
    add_entry(K_READ,  1'b0, 16'h0104, '0, 32'h1234_5678);
    add_entry(K_READ,  1'b0, 16'h0104, '0, 32'h1234_5678);
    // Region bounds
    add_entry(K_READ,  1'b1, 16'h2000, '0, mem_pattern(16'h2000));
    add_entry(K_READ,  1'b1, 16'h2000, '0, mem_pattern(16'h2000));
    add_entry(K_READ,  1'b1, 16'h2010, '0, mem_pattern(16'h2010));
    add_entry(K_READ,  1'b1, 16'h2010, '0, mem_pattern(16'h2010));
    add_entry(K_READ,  1'b1, 16'h013f, '0, mem_pattern(16'h013f));
    add_entry(K_READ,  1'b1, 16'h0140, '0, mem_pattern(16'h0140));
    // Index conflict evicts the line
    add_entry(K_READ,  1'b1, 16'h0114, '0, mem_pattern(16'h0114));
    add_entry(K_READ,  1'b1, 16'h0104, '0, 32'h1234_5678);

    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;

    for (int k = 0; k < tab_count; k++) begin
      if (tab_kind[k] == K_FLUSH) begin
        run_flush();
      end else begin
        run_access(k);
      end
    end

    repeat (4) @(posedge clk_i);
    if (u_dut.u_checker.assert_failed) begin
      $display("A bound assertion failed");
      stop_with_failure();
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/roc_pkg.sv
verilog/roc_region_decode.sv
verilog/roc_lookup.sv
verilog/roc_bypass.sv
verilog/roc_mem_arbiter.sv
verilog/roc_top.sv
test/roc_checker.sv
test/roc_tb.sv
